// File: rtl/tx_port_pkg.sv
package tx_port_pkg;

    localparam int DATA_W = 8;              // stream byte
    localparam int CNT_W  = 16;             // frame and byte statistics
    localparam int WB_DW  = 16;             // wishbone data width
    localparam int WB_AW  = 3;              // wishbone word address width
    localparam int IPG_W  = 4;              // gap register width

    localparam logic [IPG_W-1:0] IPG_RESET = 4'd12;  // gap after reset, in cycles

    // register word map
    typedef enum logic [2:0] {
        REG_CTRL      = 3'd0,               // bit 0 is the tx mac disable
        REG_GATE      = 3'd1,               // one open bit per priority
        REG_IPG       = 3'd2,
        REG_FRAME_CNT = 3'd3,               // read only
        REG_BYTE_CNT  = 3'd4                // read only
    } reg_addr_e;

    typedef enum logic [1:0] {
        SCH_IDLE = 2'd0,
        SCH_SEND = 2'd1,
        SCH_GAP  = 2'd2
    } sched_state_e;

endpackage

// File: rtl/tx_queue_bank.sv
`timescale 1ns/1ns

module tx_queue_bank #(
    parameter int PRI_NUM     = 4,
    parameter int QUEUE_DEPTH = 32
) (
    input  logic                                   i_clk,
    input  logic                                   i_rst_n,
    input  logic [tx_port_pkg::DATA_W-1:0]         i_rx_data,
    input  logic [$clog2(PRI_NUM)-1:0]             i_rx_pri,
    input  logic                                   i_rx_last,
    input  logic                                   i_rx_valid,
    output logic                                   o_rx_ready,
    input  logic                                   i_pop_en,
    input  logic [$clog2(PRI_NUM)-1:0]             i_pop_sel,
    output logic [PRI_NUM*tx_port_pkg::DATA_W-1:0] o_head_data,
    output logic [PRI_NUM-1:0]                     o_head_last,
    output logic [PRI_NUM-1:0]                     o_frame_avail
);

    localparam int DW    = tx_port_pkg::DATA_W;
    localparam int AW    = $clog2(QUEUE_DEPTH);
    localparam int PRI_W = $clog2(PRI_NUM);

    logic [PRI_NUM-1:0] full;

    assign o_rx_ready = !full[i_rx_pri];                    // only the addressed queue matters

    for (genvar q = 0; q < PRI_NUM; q++) begin : g_queue
        logic [DW:0]   mem [QUEUE_DEPTH];                   // {last, byte}
        logic [DW:0]   head;
        logic [AW-1:0] wr_ptr;
        logic [AW-1:0] rd_ptr;
        logic [AW:0]   level;                               // bytes stored
        logic [AW:0]   frame_cnt;                           // complete frames stored
        logic          wr_en;
        logic          pop;
        logic          wr_done;
        logic          pop_done;

        assign wr_en    = i_rx_valid && o_rx_ready && (i_rx_pri == PRI_W'(q));
        assign pop      = i_pop_en && (i_pop_sel == PRI_W'(q));
        assign head     = mem[rd_ptr];                      // show-ahead read
        assign wr_done  = wr_en && i_rx_last;
        assign pop_done = pop && head[DW];

        // depth is a power of two, so the msb alone flags full
        assign full[q] = level[AW];

        assign o_head_data[q*DW +: DW] = head[DW-1:0];
        assign o_head_last[q]          = head[DW];
        assign o_frame_avail[q]        = (frame_cnt != '0);

        always_ff @(posedge i_clk) begin
            if (wr_en) begin
                mem[wr_ptr] <= {i_rx_last, i_rx_data};
            end
        end

        always_ff @(posedge i_clk or negedge i_rst_n) begin
            if (!i_rst_n) begin
                wr_ptr    <= '0;
                rd_ptr    <= '0;
                level     <= '0;
                frame_cnt <= '0;
            end else begin
                if (wr_en) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (pop) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                level     <= level + {{AW{1'b0}}, wr_en} - {{AW{1'b0}}, pop};
                frame_cnt <= frame_cnt + {{AW{1'b0}}, wr_done} - {{AW{1'b0}}, pop_done};
            end
        end

        // the scheduler must only drain bytes that are really there
        a_no_pop_empty: assert property (
            @(posedge i_clk) disable iff (!i_rst_n)
            pop |-> (level != '0)
        ) else $error("pop from empty queue %0d", q);

        // fill level stops exactly at the depth
        a_no_overflow: assert property (
            @(posedge i_clk) disable iff (!i_rst_n)
            level[AW] |-> (level[AW-1:0] == '0)
        ) else $error("write into full queue %0d", q);
    end

endmodule

// File: rtl/tx_sched.sv
`timescale 1ns/1ns

module tx_sched #(
    parameter int PRI_NUM = 4
) (
    input  logic                                   i_clk,
    input  logic                                   i_rst_n,
    input  logic [PRI_NUM*tx_port_pkg::DATA_W-1:0] i_head_data,
    input  logic [PRI_NUM-1:0]                     i_head_last,
    input  logic [PRI_NUM-1:0]                     i_frame_avail,
    input  logic [PRI_NUM-1:0]                     i_gate_open,
    input  logic                                   i_txmac_down,
    input  logic [tx_port_pkg::IPG_W-1:0]          i_ipg,
    input  logic                                   i_tx_ready,
    output logic                                   o_pop_en,
    output logic [$clog2(PRI_NUM)-1:0]             o_pop_sel,
    output logic [tx_port_pkg::DATA_W-1:0]         o_tx_data,
    output logic                                   o_tx_last,
    output logic                                   o_tx_valid,
    output logic                                   o_beat,
    output logic                                   o_beat_last
);

    localparam int DW    = tx_port_pkg::DATA_W;
    localparam int PRI_W = $clog2(PRI_NUM);

    tx_port_pkg::sched_state_e      state_q;
    logic [PRI_W-1:0]               sel_q;                  // queue being sent
    logic [tx_port_pkg::IPG_W-1:0]  gap_q;                  // gap cycles left
    logic [PRI_NUM-1:0]             eligible;
    logic                           found;
    logic [PRI_W-1:0]               pick;
    logic                           handshake;

    assign eligible = i_frame_avail & i_gate_open;

    // strict priority, highest index wins
    always_comb begin
        found = 1'b0;
        pick  = '0;
        for (int i = 0; i < PRI_NUM; i++) begin
            if (eligible[i]) begin
                found = 1'b1;
                pick  = PRI_W'(i);
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= tx_port_pkg::SCH_IDLE;
            sel_q   <= '0;
            gap_q   <= '0;
        end else begin
            case (state_q)
                tx_port_pkg::SCH_IDLE: begin
                    if (!i_txmac_down && found) begin
                        sel_q   <= pick;
                        state_q <= tx_port_pkg::SCH_SEND;
                    end
                end
                tx_port_pkg::SCH_SEND: begin
                    // frame always runs to its end, gate or mac disable wait
                    if (handshake && o_tx_last) begin
                        gap_q   <= i_ipg;
                        state_q <= (i_ipg == '0) ? tx_port_pkg::SCH_IDLE
                                                 : tx_port_pkg::SCH_GAP;
                    end
                end
                tx_port_pkg::SCH_GAP: begin
                    gap_q <= gap_q - 1'b1;
                    if (gap_q == 'd1) begin
                        state_q <= tx_port_pkg::SCH_IDLE;
                    end
                end
                default: state_q <= tx_port_pkg::SCH_IDLE;
            endcase
        end
    end

    assign o_tx_valid  = (state_q == tx_port_pkg::SCH_SEND);
    assign o_tx_data   = i_head_data[sel_q*DW +: DW];       // head of latched queue
    assign o_tx_last   = i_head_last[sel_q];
    assign handshake   = o_tx_valid && i_tx_ready;
    assign o_pop_en    = handshake;                         // each accepted byte leaves the queue
    assign o_pop_sel   = sel_q;
    assign o_beat      = handshake;
    assign o_beat_last = handshake && o_tx_last;

    a_tx_stable: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_tx_valid && !i_tx_ready |=> o_tx_valid && $stable(o_tx_data) && $stable(o_tx_last)
    ) else $error("egress stream changed while stalled");

    // the frame in flight stays complete in its queue until its last byte pops
    a_pop_in_send: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_pop_en |-> (state_q == tx_port_pkg::SCH_SEND) && i_frame_avail[sel_q]
    ) else $error("pop outside a complete frame send");

endmodule

// File: rtl/tx_port_regs.sv
`timescale 1ns/1ns

module tx_port_regs #(
    parameter int PRI_NUM = 4
) (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_wb_cyc,
    input  logic                            i_wb_stb,
    input  logic                            i_wb_we,
    input  logic [tx_port_pkg::WB_AW-1:0]   i_wb_adr,
    input  logic [tx_port_pkg::WB_DW-1:0]   i_wb_dat,
    output logic [tx_port_pkg::WB_DW-1:0]   o_wb_dat,
    output logic                            o_wb_ack,
    input  logic                            i_beat,
    input  logic                            i_beat_last,
    output logic [PRI_NUM-1:0]              o_gate_open,
    output logic                            o_txmac_down,
    output logic [tx_port_pkg::IPG_W-1:0]   o_ipg
);

    localparam int IW = tx_port_pkg::IPG_W;
    localparam int CW = tx_port_pkg::CNT_W;

    tx_port_pkg::reg_addr_e         adr;
    logic                           access;                 // first cycle of a bus cycle
    logic [CW-1:0]                  frame_cnt;
    logic [CW-1:0]                  byte_cnt;
    logic [tx_port_pkg::WB_DW-1:0]  rd_data;

    assign adr    = tx_port_pkg::reg_addr_e'(i_wb_adr);
    assign access = i_wb_cyc && i_wb_stb && !o_wb_ack;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_ack     <= 1'b0;
            o_txmac_down <= 1'b0;
            o_gate_open  <= '1;                             // all gates open
            o_ipg        <= tx_port_pkg::IPG_RESET;
        end else begin
            o_wb_ack <= access;
            if (access && i_wb_we) begin
                case (adr)
                    tx_port_pkg::REG_CTRL: o_txmac_down <= i_wb_dat[0];
                    tx_port_pkg::REG_GATE: o_gate_open  <= i_wb_dat[PRI_NUM-1:0];
                    tx_port_pkg::REG_IPG:  o_ipg        <= i_wb_dat[IW-1:0];
                    default: ;                              // counters and holes ignore writes
                endcase
            end
        end
    end

    // statistics, wrap silently
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            frame_cnt <= '0;
            byte_cnt  <= '0;
        end else begin
            if (i_beat_last) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
            if (i_beat) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        rd_data = '0;
        case (adr)
            tx_port_pkg::REG_CTRL:      rd_data[0]            = o_txmac_down;
            tx_port_pkg::REG_GATE:      rd_data[PRI_NUM-1:0]  = o_gate_open;
            tx_port_pkg::REG_IPG:       rd_data[IW-1:0]       = o_ipg;
            tx_port_pkg::REG_FRAME_CNT: rd_data[CW-1:0]       = frame_cnt;
            tx_port_pkg::REG_BYTE_CNT:  rd_data[CW-1:0]       = byte_cnt;
            default:                    rd_data               = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (access && !i_wb_we) begin
            o_wb_dat <= rd_data;                            // valid with ack
        end
    end

    a_ack_pulse: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_wb_ack |=> !o_wb_ack
    ) else $error("wishbone ack not a single cycle pulse");

endmodule

// File: rtl/tx_port_mng.sv
`timescale 1ns/1ns

module tx_port_mng #(
    parameter int PRI_NUM     = 4,
    parameter int QUEUE_DEPTH = 32
) (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    // ingress stream
    input  logic [tx_port_pkg::DATA_W-1:0]  i_rx_data,
    input  logic [$clog2(PRI_NUM)-1:0]      i_rx_pri,
    input  logic                            i_rx_last,
    input  logic                            i_rx_valid,
    output logic                            o_rx_ready,
    // egress stream
    output logic [tx_port_pkg::DATA_W-1:0]  o_tx_data,
    output logic                            o_tx_last,
    output logic                            o_tx_valid,
    input  logic                            i_tx_ready,
    // wishbone slave
    input  logic                            i_wb_cyc,
    input  logic                            i_wb_stb,
    input  logic                            i_wb_we,
    input  logic [tx_port_pkg::WB_AW-1:0]   i_wb_adr,
    input  logic [tx_port_pkg::WB_DW-1:0]   i_wb_dat,
    output logic [tx_port_pkg::WB_DW-1:0]   o_wb_dat,
    output logic                            o_wb_ack
);

    localparam int PRI_W = $clog2(PRI_NUM);

    logic [PRI_NUM*tx_port_pkg::DATA_W-1:0] w_head_data;
    logic [PRI_NUM-1:0]                     w_head_last;
    logic [PRI_NUM-1:0]                     w_frame_avail;
    logic                                   w_pop_en;
    logic [PRI_W-1:0]                       w_pop_sel;
    logic [PRI_NUM-1:0]                     w_gate_open;
    logic                                   w_txmac_down;
    logic [tx_port_pkg::IPG_W-1:0]          w_ipg;
    logic                                   w_beat;
    logic                                   w_beat_last;

    tx_queue_bank #(
        .PRI_NUM        (PRI_NUM),
        .QUEUE_DEPTH    (QUEUE_DEPTH)
    ) tx_queue_bank_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_rx_data      (i_rx_data),
        .i_rx_pri       (i_rx_pri),
        .i_rx_last      (i_rx_last),
        .i_rx_valid     (i_rx_valid),
        .o_rx_ready     (o_rx_ready),
        .i_pop_en       (w_pop_en),
        .i_pop_sel      (w_pop_sel),
        .o_head_data    (w_head_data),
        .o_head_last    (w_head_last),
        .o_frame_avail  (w_frame_avail)
    );

    tx_sched #(
        .PRI_NUM        (PRI_NUM)
    ) tx_sched_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_head_data    (w_head_data),
        .i_head_last    (w_head_last),
        .i_frame_avail  (w_frame_avail),
        .i_gate_open    (w_gate_open),
        .i_txmac_down   (w_txmac_down),
        .i_ipg          (w_ipg),
        .i_tx_ready     (i_tx_ready),
        .o_pop_en       (w_pop_en),
        .o_pop_sel      (w_pop_sel),
        .o_tx_data      (o_tx_data),
        .o_tx_last      (o_tx_last),
        .o_tx_valid     (o_tx_valid),
        .o_beat         (w_beat),
        .o_beat_last    (w_beat_last)
    );

    tx_port_regs #(
        .PRI_NUM        (PRI_NUM)
    ) tx_port_regs_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_wb_cyc       (i_wb_cyc),
        .i_wb_stb       (i_wb_stb),
        .i_wb_we        (i_wb_we),
        .i_wb_adr       (i_wb_adr),
        .i_wb_dat       (i_wb_dat),
        .o_wb_dat       (o_wb_dat),
        .o_wb_ack       (o_wb_ack),
        .i_beat         (w_beat),
        .i_beat_last    (w_beat_last),
        .o_gate_open    (w_gate_open),
        .o_txmac_down   (w_txmac_down),
        .o_ipg          (w_ipg)
    );

endmodule

// File: verif/tb_tx_port_mng.sv
`timescale 1ns/1ns

module tb_tx_port_mng;

    localparam int PRI_NUM     = 4;
    localparam int QUEUE_DEPTH = 32;
    localparam int CLK_PERIOD  = 8;
    localparam int FRAME_CYC   = 2 * 16 + 15 + 4;           // stalled frame plus longest gap
    localparam int WATCHDOG_CYC = 6 * 8 * FRAME_CYC * 4;    // tests x frames x margin

    logic        i_clk = 1'b0;
    logic        i_rst_n;
    logic [7:0]  i_rx_data;
    logic [1:0]  i_rx_pri;
    logic        i_rx_last;
    logic        i_rx_valid;
    logic        o_rx_ready;
    logic [7:0]  o_tx_data;
    logic        o_tx_last;
    logic        o_tx_valid;
    logic        i_tx_ready;
    logic        i_wb_cyc;
    logic        i_wb_stb;
    logic        i_wb_we;
    logic [2:0]  i_wb_adr;
    logic [15:0] i_wb_dat;
    logic [15:0] o_wb_dat;
    logic        o_wb_ack;

    logic [8:0]  sb [PRI_NUM][$];                           // expected {last, byte} per priority
    int          pend [PRI_NUM];                            // complete frames not yet sent
    int          fill [PRI_NUM];                            // bytes held in each queue
    logic [3:0]  gate_q = 4'hf;
    logic        mac_down = 1'b0;
    int          ipg_q = 12;
    bit          in_frame;
    bit          exp_any;
    bit          rd_chk;
    bit          gap_test;
    bit          gap_armed;
    int          cur_pri;
    int          exp_pri;
    int          gap_cnt;
    logic [8:0]  exp_word;
    logic [15:0] exp_rd;
    logic [31:0] lfsr = 32'hf5b7;
    int          err_cnt;
    int          tests_run;
    int          tests_failed;
    int          err_at_start;
    int          tot_frames;
    int          tot_bytes;

    tx_port_mng #(.PRI_NUM(PRI_NUM), .QUEUE_DEPTH(QUEUE_DEPTH)) i_tx_port_mng (.*);

    always #(CLK_PERIOD / 2) i_clk = !i_clk;

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    // reference model, pre-edge values only
    always @(posedge i_clk) begin
        if (i_rx_valid && fill[i_rx_pri] < QUEUE_DEPTH) begin
            fill[i_rx_pri]++;
        end
        if (gap_armed && o_tx_valid) begin
            gap_armed = 1'b0;
        end
        gap_cnt++;
        if (o_tx_valid && i_tx_ready && sb[exp_pri].size() != 0) begin
            void'(sb[exp_pri].pop_front());
            fill[exp_pri]--;
            if (exp_word[8]) begin
                pend[exp_pri]--;
                in_frame = 1'b0;
                gap_cnt  = 0;
                gap_armed = gap_test;
            end else begin
                in_frame = 1'b1;
                cur_pri  = exp_pri;
            end
        end
        exp_any = in_frame;
        if (in_frame) begin
            exp_pri = cur_pri;
        end else begin
            for (int p = 0; p < PRI_NUM; p++) begin
                if (pend[p] != 0 && gate_q[p] && !mac_down) begin
                    exp_any = 1'b1;
                    exp_pri = p;                            // highest open wins
                end
            end
        end
        exp_word = (sb[exp_pri].size() != 0) ? sb[exp_pri][0] : 9'h000;
    end

    a_tx_data: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_tx_valid && i_tx_ready |-> {o_tx_last, o_tx_data} == exp_word
    ) else begin
        $display("Error: %0t {o_tx_last,o_tx_data} expected %h got %h", $time, exp_word,
                 {$sampled(o_tx_last), $sampled(o_tx_data)});
        err_cnt++;
    end

    a_tx_eligible: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_tx_valid |-> exp_any
    ) else begin
        $display("o_tx_valid raised at %0t with no open queue holding a frame", $time);
        err_cnt++;
    end

    a_tx_stall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_tx_valid && !i_tx_ready |=> o_tx_valid && $stable(o_tx_data) && $stable(o_tx_last)
    ) else begin
        $display("egress stream changed at %0t while stalled", $time);
        err_cnt++;
    end

    a_rx_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_rx_ready == (fill[i_rx_pri] < QUEUE_DEPTH)
    ) else begin
        $display("Error: %0t o_rx_ready expected %b got %b", $time,
                 $sampled(fill[i_rx_pri]) < QUEUE_DEPTH, $sampled(o_rx_ready));
        err_cnt++;
    end

    a_ack_timing: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wb_cyc && i_wb_stb && !o_wb_ack |=> o_wb_ack
    ) else begin
        $display("no o_wb_ack one cycle after strobe at %0t", $time);
        err_cnt++;
    end

    a_ack_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb_ack |=> !o_wb_ack
    ) else begin
        $display("o_wb_ack high for two cycles at %0t", $time);
        err_cnt++;
    end

    a_rd_data: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb_ack && rd_chk |-> o_wb_dat == exp_rd
    ) else begin
        $display("Error: %0t o_wb_dat expected %h got %h", $time, exp_rd, $sampled(o_wb_dat));
        err_cnt++;
    end

    // edges from last byte accepted to the edge that sees the next valid
    a_gap: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        gap_armed && $rose(o_tx_valid) |-> gap_cnt + 1 == ipg_q + 2
    ) else begin
        $display("Error: %0t gap edges expected %0d got %0d", $time, ipg_q + 2, gap_cnt + 1);
        err_cnt++;
    end

    task automatic bus_cycle(input logic we, input logic [2:0] adr, input logic [15:0] dat);
        @(negedge i_clk);
        rd_chk   = !we;
        exp_rd   = dat;
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we  = we;
        i_wb_adr = adr;
        i_wb_dat = we ? dat : 16'h0;
        do @(negedge i_clk); while (!o_wb_ack);
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
    endtask

    task automatic write_reg(input logic [2:0] adr, input logic [15:0] dat);
        bus_cycle(1'b1, adr, dat);
        case (adr)                                          // register now holds the value
            3'd0: mac_down = dat[0];
            3'd1: gate_q   = dat[3:0];
            3'd2: ipg_q    = dat[3:0];
            default: ;
        endcase
    endtask

    task automatic send_frame(input logic [1:0] pri, input int len);
        bit taken;
        @(negedge i_clk);
        for (int b = 0; b < len; b++) begin
            i_rx_valid = 1'b1;
            i_rx_pri   = pri;
            i_rx_data  = lfsr_bits(8);
            i_rx_last  = (b == len - 1);
            sb[pri].push_back({i_rx_last, i_rx_data});
            if (i_rx_last) begin
                pend[pri]++;
            end
            taken = 1'b0;
            while (!taken) begin
                #1 taken = o_rx_ready;
                @(negedge i_clk);
            end
        end
        i_rx_valid = 1'b0;
        tot_frames++;
        tot_bytes += len;
    endtask

    task automatic drain(input bit random_ready, input logic [3:0] mask);
        bit busy;
        busy = 1'b1;
        while (busy) begin
            @(negedge i_clk);
            i_tx_ready = random_ready ? lfsr_bits(1) : 1'b1;
            busy = 1'b0;
            for (int p = 0; p < PRI_NUM; p++) begin
                if (mask[p] && sb[p].size() != 0) begin
                    busy = 1'b1;
                end
            end
        end
        i_tx_ready = 1'b1;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_cnt != err_at_start) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", tests_run, name, (err_cnt != err_at_start) ? "failed" : "ok");
        err_at_start = err_cnt;
    endtask

    initial begin
        int pri;
        int len;
        i_rst_n = 1'b0;
        i_rx_data = '0;
        i_rx_pri = '0;
        i_rx_last = 1'b0;
        i_rx_valid = 1'b0;
        i_tx_ready = 1'b1;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we = 1'b0;
        i_wb_adr = '0;
        i_wb_dat = '0;
        repeat (5) @(negedge i_clk);
        i_rst_n = 1'b1;

        bus_cycle(1'b0, 3'd0, 16'h0000);                    // reset values
        bus_cycle(1'b0, 3'd1, 16'h000f);
        bus_cycle(1'b0, 3'd2, 16'h000c);
        bus_cycle(1'b0, 3'd3, 16'h0000);
        bus_cycle(1'b0, 3'd4, 16'h0000);
        bus_cycle(1'b0, 3'd7, 16'h0000);                    // hole reads zero
        write_reg(3'd1, 16'h0005);
        bus_cycle(1'b0, 3'd1, 16'h0005);
        write_reg(3'd2, 16'h0003);
        bus_cycle(1'b0, 3'd2, 16'h0003);
        write_reg(3'd0, 16'h0001);
        bus_cycle(1'b0, 3'd0, 16'h0001);
        write_reg(3'd0, 16'h0000);
        write_reg(3'd1, 16'h000f);
        end_test("register reset and write");

        send_frame(lfsr_bits(2), lfsr_bits(4) + 1);
        drain(1'b0, 4'hf);
        bus_cycle(1'b0, 3'd3, tot_frames);
        bus_cycle(1'b0, 3'd4, tot_bytes);
        end_test("single frame");

        write_reg(3'd0, 16'h0001);
        send_frame(2'd0, lfsr_bits(4) + 1);
        send_frame(2'd1, lfsr_bits(4) + 1);
        send_frame(2'd3, lfsr_bits(4) + 1);
        write_reg(3'd0, 16'h0000);
        drain(1'b0, 4'hf);
        end_test("strict priority");

        write_reg(3'd0, 16'h0001);
        write_reg(3'd1, 16'h0007);
        send_frame(2'd3, lfsr_bits(4) + 1);
        send_frame(2'd2, lfsr_bits(4) + 1);
        send_frame(2'd0, lfsr_bits(4) + 1);
        write_reg(3'd0, 16'h0000);
        drain(1'b0, 4'h7);
        repeat (30) @(negedge i_clk);                       // priority 3 must stay put
        write_reg(3'd1, 16'h000f);
        drain(1'b0, 4'hf);
        end_test("gating");

        write_reg(3'd0, 16'h0001);
        send_frame(2'd0, 16);                               // two frames fill priority 0
        send_frame(2'd0, 16);
        for (int f = 0; f < 6; f++) begin
            pri = lfsr_bits(2);
            len = lfsr_bits(4) + 1;
            if (sb[pri].size() + len <= QUEUE_DEPTH) begin
                send_frame(pri, len);
            end
        end
        write_reg(3'd0, 16'h0000);
        drain(1'b1, 4'hf);
        bus_cycle(1'b0, 3'd3, tot_frames);
        bus_cycle(1'b0, 3'd4, tot_bytes);
        end_test("back-pressure");

        write_reg(3'd0, 16'h0001);
        write_reg(3'd2, lfsr_bits(4));
        send_frame(2'd2, lfsr_bits(4) + 1);
        send_frame(2'd1, lfsr_bits(4) + 1);
        @(negedge i_clk);
        gap_test = 1'b1;
        write_reg(3'd0, 16'h0000);
        drain(1'b0, 4'hf);
        @(negedge i_clk);
        gap_test  = 1'b0;
        gap_armed = 1'b0;
        end_test("inter-frame gap");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYC);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: tb.f
rtl/tx_port_pkg.sv
rtl/tx_queue_bank.sv
rtl/tx_sched.sv
rtl/tx_port_regs.sv
rtl/tx_port_mng.sv
verif/tb_tx_port_mng.sv
